//--- hdl/axi_pkg.sv
package axi_pkg;

	typedef logic [3:0]  axi_id_t;
	typedef logic [1:0]  axi_resp_t;
	typedef logic [2:0]  axi_size_t;       // log2 of bytes per beat
	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [3:0]  axi_strb_t;

	localparam axi_resp_t resp_okay   = 2'b00;
	localparam axi_resp_t resp_slverr = 2'b10;

	// Read address for a single beat without len or burst
	typedef struct packed {
		axi_addr_t addr;
		axi_id_t   id;
		axi_size_t size;
	} axi_ar_t;

	typedef struct packed {
		axi_data_t data;
		axi_resp_t resp;
		axi_id_t   id;
	} axi_r_t;

	typedef axi_ar_t axi_aw_t;              // Same layout as AR

	typedef struct packed {
		axi_data_t data;
		axi_strb_t strb;
	} axi_w_t;

	typedef struct packed {
		axi_resp_t resp;
		axi_id_t   id;
	} axi_b_t;

endpackage

//--- hdl/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// Encoded like AXI size so it maps straight onto ar.size and aw.size
	typedef enum logic [1:0] {
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} mem_size_e;

	typedef struct packed {
		logic      is_store;
		mem_size_e size;
		logic      is_unsigned;             // Zero extend on loads
		addr_t     addr;
		word_t     wdata;
	} lsu_req_t;

	typedef struct packed {
		word_t rdata;                       // Zero for stores
		logic  err;
	} lsu_rsp_t;

endpackage

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter axi_pkg::axi_id_t fetch_id = 4'd1
) (
	input  logic             clock,
	input  logic             rst_n,
	input  logic             pc_valid,
	output logic             pc_ready,
	input  core_pkg::addr_t  pc,
	output logic             inst_valid,
	input  logic             inst_ready,
	output core_pkg::word_t  inst,
	output logic             inst_err,
	output axi_pkg::axi_ar_t ar,
	output logic             ar_valid,
	input  logic             ar_ready,
	input  axi_pkg::axi_r_t  r,
	input  logic             r_valid,
	output logic             r_ready
);
	import axi_pkg::*;
	import core_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_addr,
		s_data,
		s_done
	} state_e;

	state_e state;
	state_e state_n;
	addr_t  pc_q;
	logic   pc_hs;
	logic   r_hs;

	assign pc_hs = pc_valid && pc_ready;
	assign r_hs  = r_valid && r_ready;

	always_comb begin
		state_n = state;
		case (state)
			s_idle: if (pc_hs) state_n = s_addr;
			s_addr: if (ar_ready) state_n = s_data;        // ar_valid is high here
			s_data: if (r_hs) state_n = s_done;
			s_done: if (inst_ready) state_n = s_idle;
			default: state_n = s_idle;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state    <= s_idle;
			pc_ready <= 1'b0;
		end else begin
			state    <= state_n;
			pc_ready <= (state_n == s_idle);               // One request in flight
		end
	end

	always_ff @(posedge clock) begin
		if (pc_hs)
			pc_q <= pc;
		if (r_hs) begin
			inst     <= r.data;
			inst_err <= (r.resp != resp_okay);
		end
	end

	always_comb begin
		ar.addr = pc_q;
		ar.id   = fetch_id;
		ar.size = {1'b0, size_word};
	end

	assign ar_valid   = (state == s_addr);
	assign r_ready    = (state == s_data);
	assign inst_valid = (state == s_done);

endmodule

//--- hdl/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit #(
	parameter axi_pkg::axi_id_t lsu_id = 4'd2
) (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              req_valid,
	output logic              req_ready,
	input  core_pkg::lsu_req_t req,
	output logic              rsp_valid,
	input  logic              rsp_ready,
	output core_pkg::lsu_rsp_t rsp,
	output axi_pkg::axi_ar_t  ar,
	output logic              ar_valid,
	input  logic              ar_ready,
	input  axi_pkg::axi_r_t   r,
	input  logic              r_valid,
	output logic              r_ready,
	output axi_pkg::axi_aw_t  aw,
	output logic              aw_valid,
	input  logic              aw_ready,
	output axi_pkg::axi_w_t   w,
	output logic              w_valid,
	input  logic              w_ready,
	input  axi_pkg::axi_b_t   b,
	input  logic              b_valid,
	output logic              b_ready
);
	import axi_pkg::*;
	import core_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_read,
		s_write,
		s_resp,
		s_done
	} state_e;

	state_e    state;
	state_e    state_n;
	lsu_req_t  req_q;
	logic      aw_done;
	logic      w_done;
	logic      req_hs;
	logic      ar_hs;
	logic      aw_hs;
	logic      w_hs;
	logic      r_hs;
	logic      b_hs;
	axi_ar_t   ax;
	word_t     store_data;
	axi_strb_t store_strb;
	word_t     load_shift;
	word_t     load_ext;

	assign req_hs = req_valid && req_ready;
	assign ar_hs  = ar_valid && ar_ready;
	assign aw_hs  = aw_valid && aw_ready;
	assign w_hs   = w_valid && w_ready;
	assign r_hs   = r_valid && r_ready;
	assign b_hs   = b_valid && b_ready;

	always_comb begin
		state_n = state;
		case (state)
			s_idle: if (req_hs) state_n = req.is_store ? s_write : s_read;
			s_read: if (ar_hs) state_n = s_resp;
			s_write: if ((aw_done || aw_hs) && (w_done || w_hs)) state_n = s_resp;
			s_resp: if (r_hs || b_hs) state_n = s_done;
			s_done: if (rsp_ready) state_n = s_idle;
			default: state_n = s_idle;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state     <= s_idle;
			req_ready <= 1'b0;
			aw_done   <= 1'b0;
			w_done    <= 1'b0;
		end else begin
			state     <= state_n;
			req_ready <= (state_n == s_idle);
			if (req_hs) begin
				aw_done <= 1'b0;
				w_done  <= 1'b0;
			end else begin
				if (aw_hs)
					aw_done <= 1'b1;
				if (w_hs)
					w_done <= 1'b1;
			end
		end
	end

	// Store lanes with the data replicated so the strobe alone picks the bytes
	always_comb begin
		case (req_q.size)
			size_byte: begin
				store_data = {4{req_q.wdata[7:0]}};
				store_strb = 4'b0001 << req_q.addr[1:0];
			end
			size_half: begin
				store_data = {2{req_q.wdata[15:0]}};
				store_strb = 4'b0011 << {req_q.addr[1], 1'b0};
			end
			default: begin
				store_data = req_q.wdata;
				store_strb = 4'b1111;
			end
		endcase
	end

	// Load lanes move the addressed bytes down and extend
	always_comb begin
		load_shift = r.data >> {req_q.addr[1:0], 3'b000};
		case (req_q.size)
			size_byte: load_ext = {{24{~req_q.is_unsigned & load_shift[7]}}, load_shift[7:0]};
			size_half: load_ext = {{16{~req_q.is_unsigned & load_shift[15]}}, load_shift[15:0]};
			default: load_ext = load_shift;
		endcase
	end

	always_ff @(posedge clock) begin
		if (req_hs)
			req_q <= req;
		if (r_hs) begin
			rsp.rdata <= load_ext;
			rsp.err   <= (r.resp != resp_okay);
		end
		if (b_hs) begin
			rsp.rdata <= '0;
			rsp.err   <= (b.resp != resp_okay);
		end
	end

	always_comb begin
		ax.addr = req_q.addr;
		ax.id   = lsu_id;
		ax.size = {1'b0, req_q.size};
	end

	assign ar       = ax;
	assign aw       = ax;
	assign w.data   = store_data;
	assign w.strb   = store_strb;
	assign ar_valid = (state == s_read);
	assign aw_valid = (state == s_write) && !aw_done;
	assign w_valid  = (state == s_write) && !w_done;
	assign r_ready  = (state == s_resp) && !req_q.is_store;
	assign b_ready  = (state == s_resp) && req_q.is_store;
	assign rsp_valid = (state == s_done);

endmodule

//--- hdl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
	parameter axi_pkg::axi_id_t fetch_id = 4'd1,
	parameter axi_pkg::axi_id_t lsu_id   = 4'd2
) (
	input  logic             clock,
	input  logic             rst_n,
	input  axi_pkg::axi_ar_t fetch_ar,
	input  logic             fetch_ar_valid,
	output logic             fetch_ar_ready,
	output axi_pkg::axi_r_t  fetch_r,
	output logic             fetch_r_valid,
	input  logic             fetch_r_ready,
	input  axi_pkg::axi_ar_t lsu_ar,
	input  logic             lsu_ar_valid,
	output logic             lsu_ar_ready,
	output axi_pkg::axi_r_t  lsu_r,
	output logic             lsu_r_valid,
	input  logic             lsu_r_ready,
	input  axi_pkg::axi_aw_t lsu_aw,
	input  logic             lsu_aw_valid,
	output logic             lsu_aw_ready,
	input  axi_pkg::axi_w_t  lsu_w,
	input  logic             lsu_w_valid,
	output logic             lsu_w_ready,
	output axi_pkg::axi_b_t  lsu_b,
	output logic             lsu_b_valid,
	input  logic             lsu_b_ready,
	output axi_pkg::axi_ar_t m_ar,
	output logic             m_ar_valid,
	input  logic             m_ar_ready,
	input  axi_pkg::axi_r_t  m_r,
	input  logic             m_r_valid,
	output logic             m_r_ready,
	output axi_pkg::axi_aw_t m_aw,
	output logic             m_aw_valid,
	input  logic             m_aw_ready,
	output axi_pkg::axi_w_t  m_w,
	output logic             m_w_valid,
	input  logic             m_w_ready,
	input  axi_pkg::axi_b_t  m_b,
	input  logic             m_b_valid,
	output logic             m_b_ready
);

	logic last_lsu;                                    // Last AR grant went to the LSU
	logic lock;                                        // Grant frozen while AR is pending
	logic lock_lsu;
	logic grant_lsu;
	logic r_to_fetch;
	logic r_to_lsu;

	always_comb begin
		if (lock)
			grant_lsu = lock_lsu;
		else if (fetch_ar_valid && lsu_ar_valid)
			grant_lsu = !last_lsu;                     // Round robin on contention
		else
			grant_lsu = lsu_ar_valid;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			last_lsu <= 1'b0;
			lock     <= 1'b0;
			lock_lsu <= 1'b0;
		end else if (m_ar_valid && m_ar_ready) begin
			last_lsu <= grant_lsu;
			lock     <= 1'b0;
		end else if (m_ar_valid) begin
			lock     <= 1'b1;
			lock_lsu <= grant_lsu;
		end
	end

	assign m_ar           = grant_lsu ? lsu_ar : fetch_ar;
	assign m_ar_valid     = grant_lsu ? lsu_ar_valid : fetch_ar_valid;
	assign fetch_ar_ready = !grant_lsu && m_ar_ready;
	assign lsu_ar_ready   = grant_lsu && m_ar_ready;

	// Read data goes back by id since both reads may be outstanding
	assign r_to_fetch    = (m_r.id == fetch_id);
	assign r_to_lsu      = (m_r.id == lsu_id);
	assign fetch_r       = m_r;
	assign lsu_r         = m_r;
	assign fetch_r_valid = m_r_valid && r_to_fetch;
	assign lsu_r_valid   = m_r_valid && r_to_lsu;
	assign m_r_ready     = (r_to_fetch && fetch_r_ready) || (r_to_lsu && lsu_r_ready);

	// Only the LSU writes
	assign m_aw         = lsu_aw;
	assign m_aw_valid   = lsu_aw_valid;
	assign lsu_aw_ready = m_aw_ready;
	assign m_w          = lsu_w;
	assign m_w_valid    = lsu_w_valid;
	assign lsu_w_ready  = m_w_ready;
	assign lsu_b        = m_b;
	assign lsu_b_valid  = m_b_valid;
	assign m_b_ready    = lsu_b_ready;

endmodule

//--- hdl/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys #(
	parameter axi_pkg::axi_id_t fetch_id = 4'd1,
	parameter axi_pkg::axi_id_t lsu_id   = 4'd2
) (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               pc_valid,
	output logic               pc_ready,
	input  core_pkg::addr_t    pc,
	output logic               inst_valid,
	input  logic               inst_ready,
	output core_pkg::word_t    inst,
	output logic               inst_err,
	input  logic               req_valid,
	output logic               req_ready,
	input  core_pkg::lsu_req_t req,
	output logic               rsp_valid,
	input  logic               rsp_ready,
	output core_pkg::lsu_rsp_t rsp,
	output axi_pkg::axi_ar_t   m_ar,
	output logic               m_ar_valid,
	input  logic               m_ar_ready,
	input  axi_pkg::axi_r_t    m_r,
	input  logic               m_r_valid,
	output logic               m_r_ready,
	output axi_pkg::axi_aw_t   m_aw,
	output logic               m_aw_valid,
	input  logic               m_aw_ready,
	output axi_pkg::axi_w_t    m_w,
	output logic               m_w_valid,
	input  logic               m_w_ready,
	input  axi_pkg::axi_b_t    m_b,
	input  logic               m_b_valid,
	output logic               m_b_ready
);
	import axi_pkg::*;

	axi_ar_t fetch_ar;
	logic    fetch_ar_valid;
	logic    fetch_ar_ready;
	axi_r_t  fetch_r;
	logic    fetch_r_valid;
	logic    fetch_r_ready;
	axi_ar_t lsu_ar;
	logic    lsu_ar_valid;
	logic    lsu_ar_ready;
	axi_r_t  lsu_r;
	logic    lsu_r_valid;
	logic    lsu_r_ready;
	axi_aw_t lsu_aw;
	logic    lsu_aw_valid;
	logic    lsu_aw_ready;
	axi_w_t  lsu_w;
	logic    lsu_w_valid;
	logic    lsu_w_ready;
	axi_b_t  lsu_b;
	logic    lsu_b_valid;
	logic    lsu_b_ready;

	fetch_unit #(.fetch_id(fetch_id)) ifu (
		.clock, .rst_n,
		.pc_valid, .pc_ready, .pc,
		.inst_valid, .inst_ready, .inst, .inst_err,
		.ar(fetch_ar), .ar_valid(fetch_ar_valid), .ar_ready(fetch_ar_ready),
		.r(fetch_r), .r_valid(fetch_r_valid), .r_ready(fetch_r_ready)
	);

	load_store_unit #(.lsu_id(lsu_id)) lsu (
		.clock, .rst_n,
		.req_valid, .req_ready, .req,
		.rsp_valid, .rsp_ready, .rsp,
		.ar(lsu_ar), .ar_valid(lsu_ar_valid), .ar_ready(lsu_ar_ready),
		.r(lsu_r), .r_valid(lsu_r_valid), .r_ready(lsu_r_ready),
		.aw(lsu_aw), .aw_valid(lsu_aw_valid), .aw_ready(lsu_aw_ready),
		.w(lsu_w), .w_valid(lsu_w_valid), .w_ready(lsu_w_ready),
		.b(lsu_b), .b_valid(lsu_b_valid), .b_ready(lsu_b_ready)
	);

	bus_arbiter #(.fetch_id(fetch_id), .lsu_id(lsu_id)) arb (
		.clock, .rst_n,
		.fetch_ar, .fetch_ar_valid, .fetch_ar_ready,
		.fetch_r, .fetch_r_valid, .fetch_r_ready,
		.lsu_ar, .lsu_ar_valid, .lsu_ar_ready,
		.lsu_r, .lsu_r_valid, .lsu_r_ready,
		.lsu_aw, .lsu_aw_valid, .lsu_aw_ready,
		.lsu_w, .lsu_w_valid, .lsu_w_ready,
		.lsu_b, .lsu_b_valid, .lsu_b_ready,
		.m_ar, .m_ar_valid, .m_ar_ready,
		.m_r, .m_r_valid, .m_r_ready,
		.m_aw, .m_aw_valid, .m_aw_ready,
		.m_w, .m_w_valid, .m_w_ready,
		.m_b, .m_b_valid, .m_b_ready
	);

endmodule

//--- verif/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
	input  logic             clock,
	input  logic             rst_n,
	input  axi_pkg::axi_ar_t ar,
	input  logic             ar_valid,
	output logic             ar_ready,
	output axi_pkg::axi_r_t  r,
	output logic             r_valid,
	input  logic             r_ready,
	input  axi_pkg::axi_aw_t aw,
	input  logic             aw_valid,
	output logic             aw_ready,
	input  axi_pkg::axi_w_t  w,
	input  logic             w_valid,
	output logic             w_ready,
	output axi_pkg::axi_b_t  b,
	output logic             b_valid,
	input  logic             b_ready
);
	import axi_pkg::*;

	logic [31:0] mem [0:1023];                         // Filled by the testbench at time 0
	axi_ar_t     ar_q [$];
	axi_aw_t     aw_q [$];
	axi_w_t      w_q [$];
	axi_ar_t     ar_cap;
	axi_aw_t     aw_cap;
	axi_w_t      w_cap;
	logic        ar_hs;
	logic        aw_hs;
	logic        w_hs;
	logic        r_hs;
	logic        b_hs;
	int          ar_wait;
	int          aw_wait;
	int          w_wait;
	int          r_wait;
	int          b_wait;

	// Handshakes taken on the rising edge, acted on at the next falling edge
	always @(posedge clock) begin
		ar_hs  <= ar_valid && ar_ready;
		aw_hs  <= aw_valid && aw_ready;
		w_hs   <= w_valid && w_ready;
		r_hs   <= r_valid && r_ready;
		b_hs   <= b_valid && b_ready;
		ar_cap <= ar;
		aw_cap <= aw;
		w_cap  <= w;
	end

	task automatic pace_ready(input logic valid, input logic hs, inout int cnt,
			output logic ready);
		if (hs)
			cnt = $urandom_range(3, 0);                // New delay for the next request
		ready = valid && (cnt == 0);
		if (valid && cnt != 0)
			cnt--;
	endtask

	initial begin
		axi_ar_t rd;
		axi_aw_t wa;
		axi_w_t  wd;
		ar_ready = 1'b0;
		aw_ready = 1'b0;
		w_ready  = 1'b0;
		r_valid  = 1'b0;
		b_valid  = 1'b0;
		r        = '0;
		b        = '0;
		ar_wait  = 0;
		aw_wait  = 0;
		w_wait   = 0;
		r_wait   = 0;
		b_wait   = 0;
		forever begin
			@(negedge clock);
			if (!rst_n) begin
				ar_ready = 1'b0;
				aw_ready = 1'b0;
				w_ready  = 1'b0;
				r_valid  = 1'b0;
				b_valid  = 1'b0;
			end else begin
				if (ar_hs)
					ar_q.push_back(ar_cap);
				if (aw_hs)
					aw_q.push_back(aw_cap);
				if (w_hs)
					w_q.push_back(w_cap);
				pace_ready(ar_valid, ar_hs, ar_wait, ar_ready);
				pace_ready(aw_valid, aw_hs, aw_wait, aw_ready);
				pace_ready(w_valid, w_hs, w_wait, w_ready);

				// Reads answered in arrival order
				if (r_hs) begin
					r_valid = 1'b0;
					r_wait  = $urandom_range(3, 0);
				end else if (!r_valid && ar_q.size() != 0) begin
					if (r_wait == 0) begin
						rd   = ar_q.pop_front();
						r.id = rd.id;
						if (rd.addr >= 32'd4096) begin
							r.data = '0;
							r.resp = resp_slverr;
						end else begin
							r.data = mem[rd.addr[11:2]];
							r.resp = resp_okay;
						end
						r_valid = 1'b1;
					end else
						r_wait--;
				end

				// Write lands in memory when its B goes out
				if (b_hs) begin
					b_valid = 1'b0;
					b_wait  = $urandom_range(3, 0);
				end else if (!b_valid && aw_q.size() != 0 && w_q.size() != 0) begin
					if (b_wait == 0) begin
						wa   = aw_q.pop_front();
						wd   = w_q.pop_front();
						b.id = wa.id;
						b.resp = (wa.addr >= 32'd4096) ? resp_slverr : resp_okay;
						if (wa.addr < 32'd4096)
							for (int i = 0; i < 4; i++)
								if (wd.strb[i])
									mem[wa.addr[11:2]][8*i +: 8] = wd.data[8*i +: 8];
						b_valid = 1'b1;
					end else
						b_wait--;
				end
			end
		end
	end

endmodule

//--- verif/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
	import axi_pkg::*;
	import core_pkg::*;

	localparam axi_id_t fetch_id = 4'd1;
	localparam axi_id_t lsu_id   = 4'd2;

	logic     clock = 1'b0;
	logic     rst_n;
	logic     pc_valid;
	logic     pc_ready;
	addr_t    pc;
	logic     inst_valid;
	logic     inst_ready;
	word_t    inst;
	logic     inst_err;
	logic     req_valid;
	logic     req_ready;
	lsu_req_t req;
	logic     rsp_valid;
	logic     rsp_ready;
	lsu_rsp_t rsp;
	axi_ar_t  m_ar;
	logic     m_ar_valid;
	logic     m_ar_ready;
	axi_r_t   m_r;
	logic     m_r_valid;
	logic     m_r_ready;
	axi_aw_t  m_aw;
	logic     m_aw_valid;
	logic     m_aw_ready;
	axi_w_t   m_w;
	logic     m_w_valid;
	logic     m_w_ready;
	axi_b_t   m_b;
	logic     m_b_valid;
	logic     m_b_ready;
	word_t    ref_mem [0:1023];                        // Reference copy of the slave memory
	addr_t    fetch_addr;                              // pc of the fetch in flight
	lsu_req_t lsu_cur;                                 // LSU request in flight

	always #50 clock = ~clock;

	mem_subsys #(.fetch_id(fetch_id), .lsu_id(lsu_id)) uut (.*);

	axi_mem_model mem_model (
		.clock, .rst_n,
		.ar(m_ar), .ar_valid(m_ar_valid), .ar_ready(m_ar_ready),
		.r(m_r), .r_valid(m_r_valid), .r_ready(m_r_ready),
		.aw(m_aw), .aw_valid(m_aw_valid), .aw_ready(m_aw_ready),
		.w(m_w), .w_valid(m_w_valid), .w_ready(m_w_ready),
		.b(m_b), .b_valid(m_b_valid), .b_ready(m_b_ready)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input word_t got, input word_t exp);
		abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic wait_cycle(inout int n, input string what);
		@(negedge clock);
		n++;
		if (n > 200)
			abort_run($sformatf("Timed out at %0d ns waiting for %s", $time, what));
	endtask

	function automatic mem_size_e pick_size();
		case ($urandom_range(2, 0))
			0: return size_byte;
			1: return size_half;
			default: return size_word;
		endcase
	endfunction

	// AXI size code is log2 of the byte count
	function automatic logic [2:0] axi_size_of(input mem_size_e sz);
		case (sz)
			size_byte: return 3'd0;
			size_half: return 3'd1;
			default: return 3'd2;
		endcase
	endfunction

	// One in sixteen lands above the 4 KiB memory
	function automatic addr_t pick_addr(input mem_size_e sz);
		addr_t a;
		a = $urandom_range(4095, 0);
		if ($urandom_range(15, 0) == 0)
			a[12] = 1'b1;
		if (sz == size_half)
			a[0] = 1'b0;
		else if (sz == size_word)
			a[1:0] = 2'b00;
		return a;
	endfunction

	function automatic lsu_req_t pick_req(input logic store);
		lsu_req_t rq;
		rq.is_store    = store;
		rq.size        = pick_size();
		rq.is_unsigned = ($urandom_range(1, 0) == 1);
		rq.addr        = pick_addr(rq.size);
		rq.wdata       = $urandom();
		return rq;
	endfunction

	function automatic word_t expected_load(input lsu_req_t rq);
		word_t       wd;
		logic [7:0]  by;
		logic [15:0] hw;
		if (rq.addr >= 32'd4096)
			return '0;
		wd = ref_mem[rq.addr[11:2]];
		by = wd[8*rq.addr[1:0] +: 8];
		hw = rq.addr[1] ? wd[31:16] : wd[15:0];
		case (rq.size)
			size_byte: return rq.is_unsigned ? {24'b0, by} : {{24{by[7]}}, by};
			size_half: return rq.is_unsigned ? {16'b0, hw} : {{16{hw[15]}}, hw};
			default: return wd;
		endcase
	endfunction

	function automatic void apply_store(input lsu_req_t rq);
		case (rq.size)
			size_byte: ref_mem[rq.addr[11:2]][8*rq.addr[1:0] +: 8] = rq.wdata[7:0];
			size_half: ref_mem[rq.addr[11:2]][16*rq.addr[1] +: 16] = rq.wdata[15:0];
			default: ref_mem[rq.addr[11:2]] = rq.wdata;
		endcase
	endfunction

	// AXI requests carry the id, address and size of the access in flight
	always @(negedge clock) begin
		if (rst_n && m_ar_valid) begin
			if (m_ar.id == fetch_id) begin
				assert (m_ar.addr == fetch_addr)
					else mismatch("m_ar.addr", m_ar.addr, fetch_addr);
				assert (m_ar.size == 3'd2)
					else mismatch("m_ar.size", {29'b0, m_ar.size}, 32'd2);
			end else begin
				assert (m_ar.id == lsu_id)
					else mismatch("m_ar.id", {28'b0, m_ar.id}, {28'b0, lsu_id});
				assert (m_ar.addr == lsu_cur.addr)
					else mismatch("m_ar.addr", m_ar.addr, lsu_cur.addr);
				assert (m_ar.size == axi_size_of(lsu_cur.size))
					else mismatch("m_ar.size", {29'b0, m_ar.size},
						{29'b0, axi_size_of(lsu_cur.size)});
			end
		end
		if (rst_n && m_aw_valid) begin
			assert (m_aw.id == lsu_id)
				else mismatch("m_aw.id", {28'b0, m_aw.id}, {28'b0, lsu_id});
			assert (m_aw.addr == lsu_cur.addr)
				else mismatch("m_aw.addr", m_aw.addr, lsu_cur.addr);
			assert (m_aw.size == axi_size_of(lsu_cur.size))
				else mismatch("m_aw.size", {29'b0, m_aw.size},
					{29'b0, axi_size_of(lsu_cur.size)});
		end
	end

	task automatic run_fetch(input addr_t addr);
		int    n;
		int    stall;
		word_t exp;
		logic  exp_err;
		exp_err    = (addr >= 32'd4096);
		exp        = exp_err ? 32'd0 : ref_mem[addr[11:2]];
		fetch_addr = addr;
		pc         = addr;
		pc_valid   = 1'b1;
		n = 0;
		while (!pc_ready)
			wait_cycle(n, "pc_ready");
		@(negedge clock);
		pc_valid = 1'b0;
		n = 0;
		while (!inst_valid)
			wait_cycle(n, "inst_valid");
		stall = $urandom_range(4, 0);                  // Consumer not ready yet
		for (int i = 0; i <= stall; i++) begin
			if (i != 0)
				@(negedge clock);
			assert (inst_valid) else abort_run("inst_valid dropped before inst_ready");
			assert (inst == exp) else mismatch("inst", inst, exp);
			assert (inst_err == exp_err)
				else mismatch("inst_err", {31'b0, inst_err}, {31'b0, exp_err});
		end
		inst_ready = 1'b1;
		@(negedge clock);
		inst_ready = 1'b0;
	endtask

	task automatic run_lsu(input lsu_req_t rq);
		int    n;
		int    stall;
		word_t exp;
		logic  exp_err;
		exp_err   = (rq.addr >= 32'd4096);
		exp       = rq.is_store ? 32'd0 : expected_load(rq);
		lsu_cur   = rq;
		req       = rq;
		req_valid = 1'b1;
		n = 0;
		while (!req_ready)
			wait_cycle(n, "req_ready");
		@(negedge clock);
		req_valid = 1'b0;
		n = 0;
		while (!rsp_valid)
			wait_cycle(n, "rsp_valid");
		stall = $urandom_range(4, 0);
		for (int i = 0; i <= stall; i++) begin
			if (i != 0)
				@(negedge clock);
			assert (rsp_valid) else abort_run("rsp_valid dropped before rsp_ready");
			assert (rsp.rdata == exp) else mismatch("rsp.rdata", rsp.rdata, exp);
			assert (rsp.err == exp_err)
				else mismatch("rsp.err", {31'b0, rsp.err}, {31'b0, exp_err});
		end
		if (rq.is_store && !exp_err)
			apply_store(rq);                           // Error stores change nothing
		rsp_ready = 1'b1;
		@(negedge clock);
		rsp_ready = 1'b0;
	endtask

	initial begin
		lsu_req_t rq;
		lsu_req_t rd;
		addr_t    fa;
		int       kind;
		void'($urandom(32'h2b9a_4b29));
		rst_n      = 1'b0;
		pc_valid   = 1'b0;
		pc         = '0;
		inst_ready = 1'b0;
		req_valid  = 1'b0;
		req        = '0;
		rsp_ready  = 1'b0;
		fetch_addr = '0;
		lsu_cur    = '0;
		for (int i = 0; i < 1024; i++) begin
			ref_mem[i]       = $urandom();
			mem_model.mem[i] = ref_mem[i];
		end
		repeat (5) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		for (int op = 0; op < 400; op++) begin
			kind = $urandom_range(3, 0);
			fa   = pick_addr(size_word);
			rq   = pick_req(kind == 2);
			case (kind)
				0: run_fetch(fa);
				1: run_lsu(rq);
				2: begin
					run_lsu(rq);
					rd = rq;
					rd.is_store = 1'b0;
					rd.size     = size_word;
					rd.addr     = {20'b0, rq.addr[11:2], 2'b00};  // Whole stored word read back
					run_lsu(rd);
				end
				default: begin
					fork                               // Both requests on the same cycle
						run_fetch(fa);
						run_lsu(rq);
					join
				end
			endcase
		end
		$display("sim passed");
		$finish;
	end

endmodule

//--- all.f
hdl/axi_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/bus_arbiter.sv
hdl/mem_subsys.sv
verif/axi_mem_model.sv
verif/tb_mem_subsys.sv

//--- Makefile
SRCS := $(shell cat all.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_mem_subsys: all.f $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module tb_mem_subsys -o Vtb_mem_subsys

run: obj_dir/Vtb_mem_subsys
	./obj_dir/Vtb_mem_subsys > sim.log 2>&1 || true
	cat sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
